// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_exe_stage
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
src/mem_pkg.sv
src/exe_pkg.sv
src/alu.sv
src/branch_unit.sv
src/mul_div.sv
src/mem_wrap.sv
src/exe_stage.sv
sim/exe_stage_sva.sv
sim/tb_exe_stage.sv

// ==== sim/exe_stage_sva.sv ====
`timescale 1ns/1ps

module exe_stage_sva import mem_pkg::*;
(
	input logic clk,
	input logic nrst,
	input rq_t  rq,
	input rs_t  rs,
	input logic req_ack,
	input logic mem_done,
	input logic ld_misaligned,
	input logic st_misaligned
);

	// Request stays up with a steady address until the cache takes it
	property p_req_held;
		@(posedge clk) disable iff (!nrst)
		rq.val && !rs.ack && !rs.header_ack |=> rq.val && $stable(rq.address);
	endproperty

	// Done and acknowledge are one-cycle pulses
	property p_done_pulse;
		@(posedge clk) disable iff (!nrst)
		mem_done |=> !mem_done && !req_ack;
	endproperty

	property p_no_req_misaligned;
		@(posedge clk) disable iff (!nrst)
		(ld_misaligned || st_misaligned) |-> !rq.val;
	endproperty

	a_req_held: assert property (p_req_held)
		else $error("cache request dropped or changed before acknowledge");
	a_done_pulse: assert property (p_done_pulse)
		else $error("mem_done or req_ack held past one cycle");
	a_no_req_misaligned: assert property (p_no_req_misaligned)
		else $error("request raised together with a misaligned flag");

endmodule

// ==== sim/tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage
	import exe_pkg::*, mem_pkg::*;
();

	typedef enum logic [1:0] {k_pipe, k_mem, k_mis} kind_e;
	typedef enum logic [1:0] {c_idle, c_delay, c_resp} cache_state_e;

	typedef struct packed {
		issue_t      iss;
		logic [31:0] exp;   // wb.data, or load result at mem_done
		logic [31:0] tgt;
		logic        tk;
		logic        br;    // Check target and bjtaken in the issue cycle
		kind_e       kind;
	} entry_t;

	logic            clk = 1'b0;
	logic            nrst = 1'b0;
	issue_t          issue = '0;
	rs_t             rs = '0;
	wb_t             wb;
	logic [31:0]     u_imm6;
	logic [31:0]     pc6;
	logic [31:0]     target;
	logic            bjtaken;
	rq_t             rq;
	logic            req_ack;
	logic            mem_done;
	logic            ld_misaligned;
	logic            st_misaligned;

	entry_t          tbl[$];
	int              errors = 0;
	int              tests = 0;
	int              cycles = 0;
	int              limit = 0;
	logic            test_ok;

	logic [63:0]     lines [logic [28:0]];  // Sparse cache contents
	cache_state_e    cstate;
	int              ack_wait;
	rq_t             held;
	rs_t             rsp;

	always #4 clk = ~clk;

	exe_stage i_exe_stage (.*);

	bind exe_stage exe_stage_sva i_exe_stage_sva (.*);

	function automatic logic [63:0] read_line(logic [31:0] addr);
		logic [28:0] idx;
		idx = addr[31:3];
		if (lines.exists(idx))
			return lines[idx];
		return {3'b000, idx, 3'b101, ~idx};  // Untouched lines
	endfunction

	function automatic logic [63:0] write_line(logic [63:0] old, rq_t r);
		logic [63:0] line;
		line = old;
		case (r.size)
		3'd0:    line[{r.address[2:0], 3'b000} +: 8] = r.data[7:0];
		3'd1:    line[{r.address[2:1], 4'b0000} +: 16] = r.data[15:0];
		default: line[{r.address[2], 5'b00000} +: 32] = r.data;
		endcase
		return line;
	endfunction

	// Cache stand-in with 0 to 3 cycles before the acknowledge
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rsp <= '0;
			cstate <= c_idle;
			ack_wait <= 0;
		end
		else
		begin
			rsp.ack <= 1'b0;
			rsp.header_ack <= 1'b0;
			rsp.val <= 1'b0;
			case (cstate)
			c_idle:
				if (rq.val)
				begin
					held <= rq;
					ack_wait <= $urandom_range(3, 0);
					cstate <= c_delay;
				end
			c_delay:
				if (ack_wait == 0)
				begin
					rsp.ack <= (held.rqtype == rq_load);
					rsp.header_ack <= (held.rqtype == rq_store);
					if (held.rqtype == rq_store)
						lines[held.address[31:3]] = write_line(read_line(held.address), held);
					cstate <= c_resp;
				end
				else
					ack_wait <= ack_wait - 1;
			default:
			begin
				rsp.val <= 1'b1;
				rsp.data_0 <= read_line(held.address);  // Whole aligned line
				cstate <= c_idle;
			end
			endcase
		end
	end

	// Cache outputs reach the DUT just after the edge
	always @(posedge clk)
	begin
		#1;
		rs = rsp;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] ref_alu(alu_fn_e fn, logic [31:0] a, logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (fn)
		alu_add:  return a + b;
		alu_sub:  return a + ~b + 32'd1;
		alu_sll:  return a << sh;
		alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
		alu_sltu: return {31'b0, a < b};
		alu_xor:  return a ^ b;
		alu_srl:  return a >> sh;
		alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
		alu_or:   return a | b;
		default:  return a & b;
		endcase
	endfunction

	function automatic issue_t plain(logic [31:0] a, logic [31:0] b, wb_sel_e sel);
		issue_t iss;
		iss = '0;
		iss.op_a = a;
		iss.op_b = b;
		iss.rd = 5'(tbl.size() % 31 + 1);
		iss.we = 1'b1;
		iss.wb_sel = sel;
		iss.pc = 32'h0000_1000;
		return iss;
	endfunction

	task automatic push(issue_t iss, logic [31:0] exp, kind_e kind, logic br, logic tk,
		logic [31:0] tgt);
		entry_t e;
		e = '0;
		e.iss = iss;
		e.exp = exp;
		e.kind = kind;
		e.br = br;
		e.tk = tk;
		e.tgt = tgt;
		tbl.push_back(e);
	endtask

	task automatic add_alu(alu_fn_e fn, logic [31:0] a, logic [31:0] b, logic [31:0] exp);
		issue_t iss;
		iss = plain(a, b, wb_alu);
		iss.alu_fn = fn;
		push(iss, exp, k_pipe, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic add_md(md_op_e op, logic [31:0] a, logic [31:0] b, logic [31:0] exp);
		issue_t iss;
		iss = plain(a, b, wb_muldiv);
		iss.md_op = op;
		push(iss, exp, k_pipe, 1'b0, 1'b0, 32'h0);
	endtask

	// Branch at pc 0x1000 with offset -16 and the link write masked by we
	task automatic add_br(br_fn_e fn, logic [31:0] a, logic [31:0] b, logic tk);
		issue_t iss;
		iss = plain(a, b, wb_link);
		iss.we = 1'b0;
		iss.br_fn = fn;
		iss.is_branch = 1'b1;
		iss.b_imm = 32'hffff_fff0;
		push(iss, 32'h0000_1001, k_pipe, 1'b1, tk, tk ? 32'h0000_0ff0 : 32'h0000_1001);
	endtask

	task automatic add_store(mem_op_e op, logic [31:0] addr, logic [31:0] data);
		issue_t iss;
		iss = plain(addr - 32'd8, data, wb_alu);
		iss.we = 1'b0;
		iss.s_imm = 32'd8;
		iss.mem_op = op;
		push(iss, 32'h0, k_mem, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic add_load(mem_op_e op, logic [31:0] addr, logic [31:0] exp);
		issue_t iss;
		iss = plain(addr + 32'd8, 32'hffff_fff8, wb_load);  // I immediate of -8
		iss.mem_op = op;
		push(iss, exp, k_mem, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic add_mis(mem_op_e op, logic [31:0] addr);
		issue_t iss;
		iss = plain(addr, 32'h0, wb_alu);
		iss.we = 1'b0;
		iss.mem_op = op;
		push(iss, 32'h0, k_mis, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic build_table();
		issue_t      iss;
		int          off;
		int          i;
		logic [7:0]  b8;
		logic [15:0] h16;
		logic [31:0] w32;
		logic [31:0] a;
		logic [31:0] b;
		alu_fn_e     fn;
		add_alu(alu_add, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
		add_alu(alu_sub, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
		add_alu(alu_sll, 32'h0000_0001, 32'h0000_0021, 32'h0000_0002);  // Only 5 bits of shift
		add_alu(alu_slt, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0001);
		add_alu(alu_sltu, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0000);
		add_alu(alu_xor, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00);
		add_alu(alu_srl, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
		add_alu(alu_sra, 32'h8000_0000, 32'h0000_001f, 32'hffff_ffff);
		add_alu(alu_sra, 32'h4000_0000, 32'h0000_0004, 32'h0400_0000);
		add_alu(alu_or, 32'h1234_0000, 32'h0000_5678, 32'h1234_5678);
		add_alu(alu_and, 32'hff00_ff00, 32'h0f0f_0f0f, 32'h0f00_0f00);
		add_md(md_mul, 32'hffff_ffff, 32'h0000_0002, 32'hffff_fffe);
		add_md(md_mulh, 32'hffff_ffff, 32'h0000_0002, 32'hffff_ffff);
		add_md(md_mulhsu, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001);
		add_md(md_mulhsu, 32'hffff_ffff, 32'h0000_0002, 32'hffff_ffff);
		add_md(md_mulhu, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001);
		add_md(md_div, 32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd);
		add_md(md_rem, 32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff);
		add_md(md_divu, 32'hffff_fff9, 32'h0000_0003, 32'h5555_5553);
		add_md(md_div, 32'h0000_0005, 32'h0000_0000, 32'hffff_ffff);
		add_md(md_rem, 32'h0000_0005, 32'h0000_0000, 32'h0000_0005);
		add_md(md_divu, 32'h0000_0007, 32'h0000_0000, 32'hffff_ffff);
		add_md(md_remu, 32'h0000_0007, 32'h0000_0000, 32'h0000_0007);
		add_md(md_div, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);  // Signed overflow
		add_md(md_rem, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
		iss = plain(32'h0, 32'h0, wb_upper);
		iss.u_imm = 32'habcd_e000;
		push(iss, 32'habcd_e000, k_pipe, 1'b0, 1'b0, 32'h0);
		iss = plain(32'h0, 32'h0, wb_auipc);
		iss.u_imm = 32'h1234_5000;
		push(iss, 32'h1234_6000, k_pipe, 1'b0, 1'b0, 32'h0);
		add_br(br_beq, 32'd5, 32'd5, 1'b1);
		add_br(br_beq, 32'd5, 32'd6, 1'b0);
		add_br(br_bne, 32'd5, 32'd6, 1'b1);
		add_br(br_blt, 32'hffff_ffff, 32'd1, 1'b1);
		add_br(br_blt, 32'd3, 32'd3, 1'b0);
		add_br(br_bge, 32'hffff_ffff, 32'd1, 1'b0);
		add_br(br_bge, 32'd3, 32'd3, 1'b1);
		add_br(br_bltu, 32'hffff_ffff, 32'd1, 1'b0);
		add_br(br_bgeu, 32'hffff_ffff, 32'd1, 1'b1);
		iss = plain(32'h0, 32'h0, wb_link);
		iss.j = 1'b1;
		iss.j_imm = 32'h0000_0020;
		push(iss, 32'h0000_1001, k_pipe, 1'b1, 1'b1, 32'h0000_1020);
		iss = plain(32'h0000_2001, 32'h0000_0004, wb_link);
		iss.jr = 1'b1;
		push(iss, 32'h0000_1001, k_pipe, 1'b1, 1'b1, 32'h0000_2004);
		// Store then read back every byte, half and word lane of one line
		for (off = 0; off < 8; off++)
		begin
			b8 = 8'h80 + 8'(off * 8'h13);
			add_store(mem_sb, 32'h200 + off, {24'h5a5a5a, b8});
			add_load(mem_lb, 32'h200 + off, {{24{b8[7]}}, b8});
			add_load(mem_lbu, 32'h200 + off, {24'h0, b8});
		end
		for (off = 0; off < 8; off += 2)
		begin
			h16 = 16'h7f00 + 16'(off * 16'h2345);
			add_store(mem_sh, 32'h200 + off, {16'ha5a5, h16});
			add_load(mem_lh, 32'h200 + off, {{16{h16[15]}}, h16});
			add_load(mem_lhu, 32'h200 + off, {16'h0, h16});
		end
		for (off = 0; off < 8; off += 4)
		begin
			w32 = 32'hdead_beef + 32'(off) * 32'h0101_0101;
			add_store(mem_sw, 32'h200 + off, w32);
			add_load(mem_lw, 32'h200 + off, w32);
		end
		add_load(mem_lhu, 32'h206, {16'h0, w32[31:16]});  // Upper half of the last word
		add_mis(mem_lh, 32'h201);
		add_mis(mem_lw, 32'h202);
		add_mis(mem_lhu, 32'h207);
		add_mis(mem_sh, 32'h203);
		add_mis(mem_sw, 32'h205);
		for (i = 0; i < 12; i++)
		begin
			fn = alu_fn_e'($urandom_range(9, 0));
			a = $urandom();
			b = $urandom();
			add_alu(fn, a, b, ref_alu(fn, a, b));
		end
	endtask

	task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
		$display("ERROR %0t %s got %h expected %h", $time, sig, got, exp);
		errors++;
		test_ok = 1'b0;
	endtask

	task automatic drive(issue_t iss);
		@(posedge clk);
		#1;
		issue = iss;
	endtask

	task automatic run_entry(int n, entry_t e);
		logic st;
		st = e.iss.mem_op inside {mem_sb, mem_sh, mem_sw};
		test_ok = 1'b1;
		drive(e.iss);
		@(negedge clk);
		if (e.br)
		begin
			if (target !== e.tgt)
				report_mismatch("target", target, e.tgt);
			if (bjtaken !== e.tk)
				report_mismatch("bjtaken", bjtaken, e.tk);
		end
		case (e.kind)
		k_pipe:
		begin
			repeat (2) @(negedge clk);  // Stage 5, then stage 6
			if (wb.data !== e.exp)
				report_mismatch("wb.data", wb.data, e.exp);
			if (wb.rd !== e.iss.rd)
				report_mismatch("wb.rd", wb.rd, e.iss.rd);
			if (wb.we !== e.iss.we)
				report_mismatch("wb.we", wb.we, e.iss.we);
			if (u_imm6 !== e.iss.u_imm)
				report_mismatch("u_imm6", u_imm6, e.iss.u_imm);
			if (pc6 !== e.iss.pc)
				report_mismatch("pc6", pc6, e.iss.pc);
		end
		k_mem:
		begin
			while (mem_done !== 1'b1)
				@(negedge clk);
			if (req_ack !== 1'b1)
				report_mismatch("req_ack", req_ack, 1'b1);
			if (e.iss.wb_sel == wb_load)
			begin
				if (wb.data !== e.exp)
					report_mismatch("wb.data", wb.data, e.exp);
				if (wb.rd !== e.iss.rd)
					report_mismatch("wb.rd", wb.rd, e.iss.rd);
			end
		end
		default:
		begin
			@(negedge clk);  // Flag shows one cycle after issue
			if (ld_misaligned !== !st)
				report_mismatch("ld_misaligned", ld_misaligned, !st);
			if (st_misaligned !== st)
				report_mismatch("st_misaligned", st_misaligned, st);
			if (rq.val !== 1'b0)
				report_mismatch("rq.val", rq.val, 1'b0);
		end
		endcase
		tests++;
		$display("test %0d %s %s", n, e.kind.name(), test_ok ? "ok" : "failed");
	endtask

	initial
	begin
		void'($urandom(32'h53a2));
		build_table();
		limit = tbl.size() * 12 + 200;
		repeat (10) @(posedge clk);
		#1;
		nrst = 1'b1;
		@(negedge clk);
		test_ok = 1'b1;
		if ({wb.we, rq.val, req_ack, mem_done, ld_misaligned, st_misaligned} !== 6'b0)
			report_mismatch("reset outputs", {wb.we, rq.val, req_ack, mem_done,
				ld_misaligned, st_misaligned}, 32'h0);
		foreach (tbl[i])
			run_entry(i, tbl[i]);
		$display("Ran %0d tests with %0d errors", tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import exe_pkg::*;
(
	input  alu_fn_e         fn,
	input  br_fn_e          br,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	output logic [xlen-1:0] res,
	output logic            cond,
	input  logic [xlen-1:0] cond_a,
	input  logic [xlen-1:0] cond_b
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb
	begin
		case (fn)
		alu_add:  res = a + b;
		alu_sub:  res = a - b;
		alu_sll:  res = a << shamt;
		alu_slt:  res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
		alu_sltu: res = {{(xlen-1){1'b0}}, a < b};
		alu_xor:  res = a ^ b;
		alu_srl:  res = a >> shamt;
		alu_sra:  res = $signed(a) >>> shamt;  // Keeps sign bit
		alu_or:   res = a | b;
		alu_and:  res = a & b;
		default:  res = '0;
		endcase
	end

	// Branch compare on the issue-cycle operands
	always_comb
	begin
		case (br)
		br_beq:  cond = (cond_a == cond_b);
		br_bne:  cond = (cond_a != cond_b);
		br_blt:  cond = ($signed(cond_a) < $signed(cond_b));
		br_bge:  cond = ($signed(cond_a) >= $signed(cond_b));
		br_bltu: cond = (cond_a < cond_b);
		br_bgeu: cond = (cond_a >= cond_b);
		default: cond = 1'b0;
		endcase
	end

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import exe_pkg::*;
(
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b_imm,
	input  logic [xlen-1:0] j_imm,
	input  logic [xlen-1:0] i_imm,
	input  logic            taken,
	input  logic            j,
	input  logic            jr,
	output logic [xlen-1:0] target
);

	logic [xlen-1:0] jr_sum;

	assign jr_sum = a + i_imm;

	always_comb
	begin
		if (jr)
			target = {jr_sum[xlen-1:1], 1'b0};  // Bit 0 cleared
		else if (j)
			target = pc + j_imm;
		else if (taken)
			target = pc + b_imm;
		else
			target = pc + 32'd1;  // Fall through, one word on
	end

endmodule

// ==== src/exe_pkg.sv ====
package exe_pkg;
	import mem_pkg::*;

	localparam int xlen = 32;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_fn_e;

	// Writeback source select
	typedef enum logic [2:0] {
		wb_alu    = 3'd0,
		wb_link   = 3'd1,
		wb_muldiv = 3'd2,
		wb_upper  = 3'd3,
		wb_load   = 3'd4,
		wb_auipc  = 3'd5
	} wb_sel_e;

	// Encoded as RV32 branch funct3
	typedef enum logic [2:0] {
		br_beq  = 3'd0,
		br_bne  = 3'd1,
		br_blt  = 3'd4,
		br_bge  = 3'd5,
		br_bltu = 3'd6,
		br_bgeu = 3'd7
	} br_fn_e;

	typedef struct packed {
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;    // Store data, or I immediate for loads and jr
		logic [4:0]      rd;
		logic            we;
		wb_sel_e         wb_sel;
		alu_fn_e         alu_fn;
		br_fn_e          br_fn;
		logic            is_branch;
		logic            j;
		logic            jr;
		logic [xlen-1:0] b_imm;
		logic [xlen-1:0] j_imm;
		logic [xlen-1:0] u_imm;
		logic [xlen-1:0] s_imm;
		mem_op_e         mem_op;
		md_op_e          md_op;
		logic [xlen-1:0] pc;      // Word address
	} issue_t;

	typedef struct packed {
		logic [xlen-1:0] data;
		logic [4:0]      rd;
		logic            we;
	} wb_t;

endpackage

// ==== src/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage import exe_pkg::*, mem_pkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  issue_t          issue,
	output wb_t             wb,
	output logic [xlen-1:0] u_imm6,
	output logic [xlen-1:0] pc6,
	output logic [xlen-1:0] target,
	output logic            bjtaken,
	output rq_t             rq,
	input  rs_t             rs,
	output logic            req_ack,
	output logic            mem_done,
	output logic            ld_misaligned,
	output logic            st_misaligned
);

	// Stage 6 holds finished results only
	typedef struct packed {
		logic [xlen-1:0] alu_res;
		logic [xlen-1:0] md_res;
		logic [xlen-1:0] upper;
		logic [xlen-1:0] auipc;
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		logic            we;
		wb_sel_e         wb_sel;
	} s6_t;

	issue_t          s5;
	s6_t             s6;
	logic [xlen-1:0] alu_res;
	logic [xlen-1:0] md_res;
	logic [xlen-1:0] mem_data;
	logic            br_cond;
	logic            br_taken;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			s5 <= '0;
		else
			s5 <= issue;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			s6 <= '0;
		else
		begin
			s6.alu_res <= alu_res;
			s6.md_res <= md_res;
			s6.upper <= s5.u_imm;
			s6.auipc <= s5.pc + s5.u_imm;
			s6.pc <= s5.pc;
			s6.rd <= s5.rd;
			s6.we <= s5.we;
			s6.wb_sel <= s5.wb_sel;
		end
	end

	alu i_alu (
		.fn     (s5.alu_fn),
		.br     (issue.br_fn),
		.a      (s5.op_a),
		.b      (s5.op_b),
		.res    (alu_res),
		.cond   (br_cond),
		.cond_a (issue.op_a),  // Taken decision in the issue cycle
		.cond_b (issue.op_b)
	);

	assign br_taken = br_cond && issue.is_branch;
	assign bjtaken = br_taken || issue.j || issue.jr;

	branch_unit i_branch_unit (
		.pc     (issue.pc),
		.a      (issue.op_a),
		.b_imm  (issue.b_imm),
		.j_imm  (issue.j_imm),
		.i_imm  (issue.op_b),
		.taken  (br_taken),
		.j      (issue.j),
		.jr     (issue.jr),
		.target (target)
	);

	mul_div i_mul_div (
		.a   (s5.op_a),
		.b   (s5.op_b),
		.op  (s5.md_op),
		.res (md_res)
	);

	mem_wrap i_mem_wrap (
		.clk           (clk),
		.nrst          (nrst),
		.op            (issue.mem_op),
		.base          (issue.op_a),
		.src           (issue.op_b),
		.s_imm         (issue.s_imm),
		.i_imm         (issue.op_b),
		.rq            (rq),
		.rs            (rs),
		.req_ack       (req_ack),
		.data          (mem_data),
		.done          (mem_done),
		.ld_misaligned (ld_misaligned),
		.st_misaligned (st_misaligned)
	);

	always_comb
	begin
		wb.rd = s6.rd;
		wb.we = s6.we;
		case (s6.wb_sel)
		wb_alu:    wb.data = s6.alu_res;
		wb_link:   wb.data = s6.pc + 32'd1;  // Return word address
		wb_muldiv: wb.data = s6.md_res;
		wb_upper:  wb.data = s6.upper;
		wb_load:   wb.data = mem_data;
		wb_auipc:  wb.data = s6.auipc;
		default:   wb.data = '0;
		endcase
	end

	assign u_imm6 = s6.upper;
	assign pc6 = s6.pc;

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

	// Load/store kinds seen by the memory wrapper
	typedef enum logic [3:0] {
		mem_none = 4'd0,
		mem_lb,
		mem_lh,
		mem_lw,
		mem_lbu,
		mem_lhu,
		mem_sb,
		mem_sh,
		mem_sw
	} mem_op_e;

	typedef enum logic [2:0] {
		md_mul, md_mulh, md_mulhsu, md_mulhu,
		md_div, md_divu, md_rem, md_remu
	} md_op_e;

	localparam logic [3:0] rq_load  = 4'b0000;
	localparam logic [3:0] rq_store = 4'b0001;

	// Request to the L1.5 port
	typedef struct packed {
		logic [3:0]  rqtype;
		logic [2:0]  size;     // 0 byte, 1 half, 2 word
		logic [31:0] address;
		logic [31:0] data;
		logic        val;
	} rq_t;

	typedef struct packed {
		logic [63:0] data_0;
		logic [3:0]  returntype;
		logic        val;
		logic        ack;         // Load request taken
		logic        header_ack;  // Store request taken
	} rs_t;

	// One returned 64-bit line, little endian lanes
	typedef union packed {
		logic [1:0][31:0] words;
		logic [7:0][7:0]  bytes;
	} line_u;

endpackage

// ==== src/mem_wrap.sv ====
`timescale 1ns/1ps

module mem_wrap import exe_pkg::*, mem_pkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  mem_op_e         op,
	input  logic [xlen-1:0] base,
	input  logic [xlen-1:0] src,
	input  logic [xlen-1:0] s_imm,
	input  logic [xlen-1:0] i_imm,
	output rq_t             rq,
	input  rs_t             rs,
	output logic            req_ack,
	output logic [xlen-1:0] data,
	output logic            done,
	output logic            ld_misaligned,
	output logic            st_misaligned
);

	typedef enum logic [1:0] {st_idle, st_req, st_wait} state_e;

	state_e          state;
	logic            is_load;
	logic            is_store;
	logic            misaligned;
	logic            start;
	logic [xlen-1:0] addr;
	logic [2:0]      size;
	logic [xlen-1:0] st_data;

	// Held request fields
	logic [3:0]      rq_type;
	logic [2:0]      rq_size;
	logic [xlen-1:0] rq_addr;
	logic [xlen-1:0] rq_data;
	mem_op_e         ld_op;
	logic [2:0]      ld_off;  // Lane within the 64-bit line

	line_u           line;
	logic [7:0]      ld_byte;
	logic [15:0]     ld_half;
	logic [xlen-1:0] ld_val;
	logic [xlen-1:0] data_q;

	always_comb
	begin
		is_load = op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
		is_store = op inside {mem_sb, mem_sh, mem_sw};
		addr = base + (is_store ? s_imm : i_imm);
		case (op)
		mem_lh, mem_lhu, mem_sh:
		begin
			size = 3'd1;
			misaligned = addr[0];
		end
		mem_lw, mem_sw:
		begin
			size = 3'd2;
			misaligned = |addr[1:0];
		end
		default:
		begin
			size = 3'd0;
			misaligned = 1'b0;
		end
		endcase
		// Narrow stores are replicated across the word
		case (op)
		mem_sb:  st_data = {4{src[7:0]}};
		mem_sh:  st_data = {2{src[15:0]}};
		default: st_data = src;
		endcase
	end

	assign start = (state == st_idle) && (is_load || is_store) && !misaligned;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= st_idle;
			ld_misaligned <= 1'b0;
			st_misaligned <= 1'b0;
		end
		else
		begin
			ld_misaligned <= (state == st_idle) && is_load && misaligned;
			st_misaligned <= (state == st_idle) && is_store && misaligned;
			case (state)
			st_idle:
				if (start)
					state <= st_req;
			st_req:
				if (rq_type == rq_store ? rs.header_ack : rs.ack)
					state <= st_wait;
			st_wait:
				if (rs.val)
					state <= st_idle;
			default:
				state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			rq_type <= is_store ? rq_store : rq_load;
			rq_size <= size;
			rq_addr <= addr;
			rq_data <= st_data;
			ld_op <= op;
			ld_off <= addr[2:0];
		end
		if (done && rq_type == rq_load)
			data_q <= ld_val;
	end

	always_comb
	begin
		rq.rqtype = rq_type;
		rq.size = rq_size;
		rq.address = rq_addr;
		rq.data = rq_data;
		rq.val = (state == st_req);
	end

	// Lane pick and extension of the returned line
	always_comb
	begin
		line = rs.data_0;
		ld_byte = line.bytes[ld_off];
		ld_half = {line.bytes[{ld_off[2:1], 1'b1}], line.bytes[{ld_off[2:1], 1'b0}]};
		case (ld_op)
		mem_lb:  ld_val = {{24{ld_byte[7]}}, ld_byte};
		mem_lbu: ld_val = {24'b0, ld_byte};
		mem_lh:  ld_val = {{16{ld_half[15]}}, ld_half};
		mem_lhu: ld_val = {16'b0, ld_half};
		default: ld_val = line.words[ld_off[2]];
		endcase
	end

	assign done = (state == st_wait) && rs.val;
	assign req_ack = done;
	assign data = (done && rq_type == rq_load) ? ld_val : data_q;  // Bypass on return

endmodule

// ==== src/mul_div.sv ====
`timescale 1ns/1ps

module mul_div import exe_pkg::*, mem_pkg::*;
(
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  md_op_e          op,
	output logic [xlen-1:0] res
);

	logic [63:0]     prod_ss;
	logic [63:0]     prod_uu;
	logic [63:0]     prod_su;
	logic            div_zero;
	logic            overflow;
	logic [xlen-1:0] quot_s;
	logic [xlen-1:0] quot_u;
	logic [xlen-1:0] rem_s;
	logic [xlen-1:0] rem_u;

	assign prod_ss = $signed(a) * $signed(b);
	assign prod_uu = {32'b0, a} * {32'b0, b};
	assign prod_su = $signed({a[xlen-1], a}) * $signed({1'b0, b});  // a signed, b unsigned

	assign div_zero = (b == '0);
	assign overflow = (a == 32'h8000_0000) && (b == '1);

	always_comb
	begin
		quot_u = div_zero ? '1 : a / b;
		rem_u = div_zero ? a : a % b;
		if (div_zero)
		begin
			quot_s = '1;
			rem_s = a;
		end
		else if (overflow)
		begin
			// Most negative divided by -1
			quot_s = a;
			rem_s = '0;
		end
		else
		begin
			quot_s = $signed(a) / $signed(b);
			rem_s = $signed(a) % $signed(b);
		end
	end

	always_comb
	begin
		case (op)
		md_mul:    res = prod_ss[31:0];
		md_mulh:   res = prod_ss[63:32];
		md_mulhsu: res = prod_su[63:32];
		md_mulhu:  res = prod_uu[63:32];
		md_div:    res = quot_s;
		md_divu:   res = quot_u;
		md_rem:    res = rem_s;
		default:   res = rem_u;
		endcase
	end

endmodule
